// ==== dl11_pkg.sv ====
/*
 * shared types and constants for the DL11 serial line unit
 * register offsets are byte offsets from the unit base address
 * vectors are the console values; other units need other vectors
 */
package dl11_pkg;

   // I/O page data word and serial character
   typedef logic [15:0] word_t;
   typedef logic [7:0]  byte_t;

   // one I/O page access, rd and wr are single cycle strobes
   typedef struct packed {
      logic [12:0] addr;
      word_t       wdata;
      logic        rd;
      logic        wr;
      logic        byte_op;
   } iopage_req_t;

   // register offsets from the base
   localparam logic [12:0] REG_RCSR = 13'o0;
   localparam logic [12:0] REG_RBUF = 13'o2;
   localparam logic [12:0] REG_XCSR = 13'o4;
   localparam logic [12:0] REG_XBUF = 13'o6;

   // receiver done and transmitter ready share a position
   localparam int CSR_DONE_BIT = 7;
   localparam int CSR_IE_BIT   = 6;

   // interrupt vectors
   localparam byte_t VEC_RX = 8'o60;
   localparam byte_t VEC_TX = 8'o64;

   // 16x ticks per serial bit
   localparam int OVERSAMPLE = 16;

endpackage

// ==== dl11_brg.sv ====
/*
 * baud tick generator, both ticks are single clk enables
 * BAUD_DIV is limited to 65536 and OVERSAMPLE must be a power of two
 */
`timescale 1ns/1ps

module dl11_brg #(
   parameter int unsigned BAUD_DIV = 4
) (
   input  logic clk,
   input  logic reset,
   output logic tick16,
   output logic tick1
);
   import dl11_pkg::*;

   localparam int OS_W = $clog2(OVERSAMPLE);

   logic [15:0]     div_cnt;
   logic [OS_W-1:0] os_cnt;

   assign tick16 = (div_cnt == 16'(BAUD_DIV - 1));
   assign tick1  = tick16 && (os_cnt == OS_W'(OVERSAMPLE - 1));

   // prescaler, then the oversample counter advances on each 16x tick
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         os_cnt  <= '0;
      end
      else if (tick16)
      begin
         div_cnt <= '0;
         if (tick1)
            os_cnt <= '0;
         else
            os_cnt <= os_cnt + 1'b1;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

endmodule

// ==== dl11_uart_tx.sv ====
/*
 * 8N1 serial transmitter, one bit per tick1
 * a byte is taken over the four-phase ld_tx_req/ld_tx_ack handshake
 * frames go out back to back when the holding register is refilled in time
 */
`timescale 1ns/1ps

module dl11_uart_tx (
   input  logic            clk,
   input  logic            reset,
   input  logic            tick1,
   input  logic            ld_tx_req,
   output logic            ld_tx_ack,
   input  dl11_pkg::byte_t tx_data,
   output logic            tx_empty,
   output logic            tx_out
);
   import dl11_pkg::*;

   byte_t      hold_data;
   logic       hold_full;
   logic       take;
   logic [9:0] shift_reg;
   logic [3:0] bit_cnt;
   logic       busy;

   // accept only when the holding register is free
   assign take     = ld_tx_req && !ld_tx_ack && !hold_full;
   assign tx_empty = !hold_full && !busy;
   assign tx_out   = shift_reg[0];

   always_ff @(posedge clk)
   begin
      if (take)
         hold_data <= tx_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ld_tx_ack <= 1'b0;
         hold_full <= 1'b0;
         shift_reg <= '1;
         bit_cnt   <= '0;
         busy      <= 1'b0;
      end
      else
      begin
         // ack stays up until the requester drops req
         if (!ld_tx_req)
            ld_tx_ack <= 1'b0;
         else if (take)
         begin
            ld_tx_ack <= 1'b1;
            hold_full <= 1'b1;
         end

         if (tick1)
         begin
            if (busy && bit_cnt != 4'd9)
            begin
               // idle level shifts in behind the frame
               shift_reg <= {1'b1, shift_reg[9:1]};
               bit_cnt   <= bit_cnt + 1'b1;
            end
            else if (hold_full)
            begin
               // stop, data lsb first, start
               shift_reg <= {1'b1, hold_data, 1'b0};
               bit_cnt   <= '0;
               busy      <= 1'b1;
               hold_full <= 1'b0;
            end
            else
               busy <= 1'b0;
         end
      end
   end

endmodule

// ==== dl11_uart_rx.sv ====
/*
 * 8N1 serial receiver sampling on the 16x tick
 * a frame with a bad stop bit is dropped without any error flag
 * a new byte overwrites a holding register that was not unloaded
 */
`timescale 1ns/1ps

module dl11_uart_rx (
   input  logic            clk,
   input  logic            reset,
   input  logic            tick16,
   input  logic            rx_in,
   input  logic            uld_rx_req,
   output logic            uld_rx_ack,
   output dl11_pkg::byte_t rx_data,
   output logic            rx_empty
);
   import dl11_pkg::*;

   localparam int OS_W = $clog2(OVERSAMPLE);
   localparam logic [OS_W-1:0] HALF = OS_W'(OVERSAMPLE / 2 - 1);
   localparam logic [OS_W-1:0] FULL = OS_W'(OVERSAMPLE - 1);

   typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

   state_t          state;
   logic            rx_meta;
   logic            rx_sync;
   logic            rx_prev;
   logic [OS_W-1:0] os_cnt;
   logic [2:0]      bit_idx;
   logic            sample;
   logic            stop_ok;
   byte_t           shift_reg;
   byte_t           hold_data;
   logic            hold_full;

   // os_cnt reaches FULL at the middle of each bit after the start check
   assign sample   = tick16 && (os_cnt == FULL);
   assign stop_ok  = (state == S_STOP) && sample && rx_sync;
   assign rx_data  = hold_data;
   assign rx_empty = !hold_full;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_meta <= rx_in;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= S_IDLE;
         os_cnt  <= '0;
         bit_idx <= '0;
      end
      else
      begin
         case (state)
            S_IDLE:
               if (rx_prev && !rx_sync)
               begin
                  state  <= S_START;
                  os_cnt <= '0;
               end
            S_START:
               if (tick16)
               begin
                  // half a bit in, the line must still be low
                  if (os_cnt == HALF)
                  begin
                     os_cnt  <= '0;
                     bit_idx <= '0;
                     state   <= rx_sync ? S_IDLE : S_DATA;
                  end
                  else
                     os_cnt <= os_cnt + 1'b1;
               end
            S_DATA:
               if (sample)
               begin
                  os_cnt  <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= S_STOP;
               end
               else if (tick16)
                  os_cnt <= os_cnt + 1'b1;
            default:
               if (sample)
                  state <= S_IDLE;
               else if (tick16)
                  os_cnt <= os_cnt + 1'b1;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == S_DATA && sample)
         shift_reg <= {rx_sync, shift_reg[7:1]};
      if (stop_ok)
         hold_data <= shift_reg;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         uld_rx_ack <= 1'b0;
         hold_full  <= 1'b0;
      end
      else
      begin
         if (!uld_rx_req)
            uld_rx_ack <= 1'b0;
         else if (hold_full && !uld_rx_ack)
         begin
            uld_rx_ack <= 1'b1;
            hold_full  <= 1'b0;
         end
         // a fresh byte wins over the unload
         if (stop_ok)
            hold_full <= 1'b1;
      end
   end

endmodule

// ==== dl11_regs.sv ====
/*
 * DL11 register block: RCSR, RBUF, XCSR, XBUF at BASE_ADDR + 0..6
 * BASE_ADDR must be 8-byte aligned; reads are combinational
 * an XBUF write while a load is in progress updates XBUF but starts no load
 */
`timescale 1ns/1ps

module dl11_regs #(
   parameter logic [12:0] BASE_ADDR = 13'o17560
) (
   input  logic                  clk,
   input  logic                  reset,
   input  dl11_pkg::iopage_req_t req,
   output dl11_pkg::word_t       rdata,
   output logic                  decode,
   output logic                  interrupt,
   input  logic                  interrupt_ack,
   output dl11_pkg::byte_t       vector,
   output logic                  ld_tx_req,
   input  logic                  ld_tx_ack,
   output dl11_pkg::byte_t       tx_data,
   input  logic                  tx_empty,
   output logic                  uld_rx_req,
   input  logic                  uld_rx_ack,
   input  dl11_pkg::byte_t       rx_data,
   input  logic                  rx_empty
);
   import dl11_pkg::*;

   typedef enum logic [1:0] {TX_IDLE, TX_WAIT_ACK, TX_WAIT_NACK, TX_DONE} tx_state_t;
   typedef enum logic [2:0] {
      RX_IDLE, RX_WAIT_ACK, RX_WAIT_NACK, RX_FULL, RX_CLEAR
   } rx_state_t;

   tx_state_t   tx_state;
   rx_state_t   rx_state;
   logic [12:0] offset;
   word_t       reg_out;
   word_t       reg_in;
   word_t       xbuf;
   byte_t       rbuf;
   logic        rx_ie;
   logic        tx_ie;
   logic        wr_hit;
   logic        xbuf_wr;
   logic        rbuf_rd;
   logic        tx_empty_q;
   logic        tx_empty_d;
   logic        tx_ready;
   logic        rx_done;
   logic        tx_flag;
   logic        rx_flag;
   logic        asserting_tx;
   logic        asserting_rx;
   logic [1:0]  int_out;

   // both bytes of each word register decode
   assign decode  = (req.addr[12:3] == BASE_ADDR[12:3]);
   assign offset  = {10'd0, req.addr[2:1], 1'b0};
   assign wr_hit  = req.wr && decode;
   assign xbuf_wr = wr_hit && (offset == REG_XBUF);
   assign rbuf_rd = req.rd && decode && (offset == REG_RBUF);

   assign tx_ready = tx_empty_q && (tx_state == TX_IDLE);
   assign rx_done  = (rx_state == RX_FULL);

   always_comb
   begin
      reg_out = '0;
      if (req.rd && decode)
      begin
         case (offset)
            REG_RCSR:
            begin
               reg_out[CSR_DONE_BIT] = rx_done;
               reg_out[CSR_IE_BIT]   = rx_ie;
            end
            REG_RBUF: reg_out = {8'h00, rbuf};
            REG_XCSR:
            begin
               reg_out[CSR_DONE_BIT] = tx_ready;
               reg_out[CSR_IE_BIT]   = tx_ie;
            end
            default:  reg_out = xbuf;
         endcase
      end
   end

   // odd byte accesses use the high lane, moved down to the low lane
   always_comb
   begin
      if (!req.byte_op)
         rdata = reg_out;
      else if (req.addr[0])
         rdata = {8'h00, reg_out[15:8]};
      else
         rdata = {8'h00, reg_out[7:0]};
   end

   assign reg_in = (req.byte_op && req.addr[0]) ? {8'h00, req.wdata[15:8]} : req.wdata;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_ie <= 1'b0;
         tx_ie <= 1'b0;
         xbuf  <= '0;
      end
      else if (wr_hit)
      begin
         case (offset)
            REG_RCSR: rx_ie <= reg_in[CSR_IE_BIT];
            REG_XCSR: tx_ie <= reg_in[CSR_IE_BIT];
            REG_XBUF: xbuf  <= reg_in;
            default:  ;
         endcase
      end
   end

   // transmit sequencer, one load per XBUF write
   assign ld_tx_req = (tx_state == TX_WAIT_ACK);
   assign tx_data   = xbuf[7:0];

   always_ff @(posedge clk)
   begin
      if (reset)
         tx_state <= TX_IDLE;
      else
      begin
         case (tx_state)
            TX_IDLE:      if (xbuf_wr) tx_state <= TX_WAIT_ACK;
            TX_WAIT_ACK:  if (ld_tx_ack) tx_state <= TX_WAIT_NACK;
            TX_WAIT_NACK: if (!ld_tx_ack) tx_state <= TX_DONE;
            default:      tx_state <= TX_IDLE;
         endcase
      end
   end

   // receive sequencer, done is held until software reads RBUF
   assign uld_rx_req = (rx_state == RX_WAIT_ACK);

   always_ff @(posedge clk)
   begin
      if (reset)
         rx_state <= RX_IDLE;
      else
      begin
         case (rx_state)
            RX_IDLE:      if (!rx_empty) rx_state <= RX_WAIT_ACK;
            RX_WAIT_ACK:  if (uld_rx_ack) rx_state <= RX_WAIT_NACK;
            RX_WAIT_NACK: if (!uld_rx_ack) rx_state <= RX_FULL;
            RX_FULL:      if (rbuf_rd) rx_state <= RX_CLEAR;
            default:      rx_state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_state == RX_WAIT_ACK && uld_rx_ack)
         rbuf <= rx_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_empty_q <= 1'b0;
         tx_empty_d <= 1'b0;
      end
      else
      begin
         tx_empty_q <= tx_empty;
         tx_empty_d <= tx_empty_q;
      end
   end

   assign asserting_rx = rx_ie && rx_flag;
   assign asserting_tx = tx_ie && tx_flag;

   // tx flag starts set so enabling XCSR IE on an idle line interrupts
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_flag <= 1'b1;
         rx_flag <= 1'b0;
      end
      else
      begin
         if (tx_empty_q && !tx_empty_d)
            tx_flag <= 1'b1;
         else if (xbuf_wr || (interrupt_ack && !asserting_rx && asserting_tx))
            tx_flag <= 1'b0;

         if (rx_state == RX_WAIT_NACK && !uld_rx_ack)
            rx_flag <= 1'b1;
         else if (rbuf_rd || (interrupt_ack && asserting_rx))
            rx_flag <= 1'b0;
      end
   end

   // receive has priority; vector holds still during an ack cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         int_out <= 2'b00;
         vector  <= VEC_TX;
      end
      else if (interrupt_ack)
      begin
         if (asserting_rx)
            int_out[0] <= 1'b0;
         else if (asserting_tx)
            int_out[1] <= 1'b0;
      end
      else
      begin
         int_out <= {asserting_tx, asserting_rx};
         vector  <= asserting_rx ? VEC_RX : VEC_TX;
      end
   end

   assign interrupt = |int_out;

endmodule

// ==== dl11_top.sv ====
/*
 * DL11 serial line unit on a single clock
 * one bit lasts OVERSAMPLE * BAUD_DIV clk cycles
 */
`timescale 1ns/1ps

module dl11_top #(
   parameter logic [12:0] BASE_ADDR = 13'o17560,
   parameter int unsigned BAUD_DIV  = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   input  dl11_pkg::iopage_req_t req,
   output dl11_pkg::word_t       rdata,
   output logic                  decode,
   output logic                  interrupt,
   input  logic                  interrupt_ack,
   output dl11_pkg::byte_t       vector,
   output logic                  rs232_tx,
   input  logic                  rs232_rx
);
   import dl11_pkg::*;

   logic  tick16;
   logic  tick1;
   logic  ld_tx_req;
   logic  ld_tx_ack;
   logic  tx_empty;
   byte_t tx_data;
   logic  uld_rx_req;
   logic  uld_rx_ack;
   logic  rx_empty;
   byte_t rx_data;

   dl11_regs #(
      .BASE_ADDR (BASE_ADDR)
   ) i_dl11_regs (
      .clk           (clk),
      .reset         (reset),
      .req           (req),
      .rdata         (rdata),
      .decode        (decode),
      .interrupt     (interrupt),
      .interrupt_ack (interrupt_ack),
      .vector        (vector),
      .ld_tx_req     (ld_tx_req),
      .ld_tx_ack     (ld_tx_ack),
      .tx_data       (tx_data),
      .tx_empty      (tx_empty),
      .uld_rx_req    (uld_rx_req),
      .uld_rx_ack    (uld_rx_ack),
      .rx_data       (rx_data),
      .rx_empty      (rx_empty)
   );

   dl11_brg #(
      .BAUD_DIV (BAUD_DIV)
   ) i_dl11_brg (
      .clk    (clk),
      .reset  (reset),
      .tick16 (tick16),
      .tick1  (tick1)
   );

   dl11_uart_tx i_dl11_uart_tx (
      .clk       (clk),
      .reset     (reset),
      .tick1     (tick1),
      .ld_tx_req (ld_tx_req),
      .ld_tx_ack (ld_tx_ack),
      .tx_data   (tx_data),
      .tx_empty  (tx_empty),
      .tx_out    (rs232_tx)
   );

   dl11_uart_rx i_dl11_uart_rx (
      .clk        (clk),
      .reset      (reset),
      .tick16     (tick16),
      .rx_in      (rs232_rx),
      .uld_rx_req (uld_rx_req),
      .uld_rx_ack (uld_rx_ack),
      .rx_data    (rx_data),
      .rx_empty   (rx_empty)
   );

endmodule

// ==== tb_dl11.sv ====
/*
 * testbench for the DL11 serial line unit
 * serial timing assumes BAUD_DIV 4, so 64 clk cycles per bit
 * register reads are checked against a model of the programmer-visible state
 */
`timescale 1ns/1ps

module tb_dl11;
   import dl11_pkg::*;

   localparam logic [12:0] BASE_ADDR      = 13'o17560;
   localparam int          BAUD_DIV       = 4;
   localparam int          BIT_CLKS       = OVERSAMPLE * BAUD_DIV;
   localparam int          TIMEOUT_CYCLES = 24 * 640 + 2000;

   logic        clk;
   logic        reset;
   iopage_req_t req;
   word_t       rdata;
   logic        decode;
   logic        interrupt;
   logic        interrupt_ack;
   byte_t       vector;
   logic        rs232_tx;
   logic        rs232_rx;

   // model of the register state as software sees it
   word_t       m_xbuf;
   byte_t       m_rbuf;
   logic        m_rx_ie;
   logic        m_tx_ie;
   logic        m_rx_done;
   logic        m_tx_ready;

   string       test_name;
   logic        check_en;
   logic [31:0] lcg_state;
   int          errors;
   int          checks;
   int          cycle_count;
   byte_t       tx_seen[$];

   dl11_top #(
      .BASE_ADDR (BASE_ADDR),
      .BAUD_DIV  (BAUD_DIV)
   ) i_dl11_top (
      .clk           (clk),
      .reset         (reset),
      .req           (req),
      .rdata         (rdata),
      .decode        (decode),
      .interrupt     (interrupt),
      .interrupt_ack (interrupt_ack),
      .vector        (vector),
      .rs232_tx      (rs232_tx),
      .rs232_rx      (rs232_rx)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [15:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];
   endfunction

   function automatic logic expected_decode(input logic [12:0] addr);
      return (addr >= BASE_ADDR) && (addr < BASE_ADDR + 13'd8);
   endfunction

   function automatic word_t expected_rdata(input logic [12:0] addr, input logic byte_op);
      word_t       w;
      logic [12:0] off;
      w   = '0;
      off = addr - BASE_ADDR;
      if (expected_decode(addr))
      begin
         case ({off[12:1], 1'b0})
            REG_RCSR:
            begin
               w[CSR_DONE_BIT] = m_rx_done;
               w[CSR_IE_BIT]   = m_rx_ie;
            end
            REG_RBUF: w = {8'h00, m_rbuf};
            REG_XCSR:
            begin
               w[CSR_DONE_BIT] = m_tx_ready;
               w[CSR_IE_BIT]   = m_tx_ie;
            end
            default:  w = m_xbuf;
         endcase
      end
      // odd byte reads come back in the low lane
      if (byte_op)
         w = addr[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
      return w;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic bus_read(input logic [12:0] addr, input logic byte_op, input logic check,
                           output word_t data);
      @(negedge clk);
      req      = '{addr: addr, wdata: '0, rd: 1'b1, wr: 1'b0, byte_op: byte_op};
      check_en = check;
      @(posedge clk);
      data = rdata;
      @(negedge clk);
      req.rd   = 1'b0;
      check_en = 1'b0;
   endtask

   task automatic bus_write(input logic [12:0] addr, input word_t wdata, input logic byte_op);
      @(negedge clk);
      req = '{addr: addr, wdata: wdata, rd: 1'b0, wr: 1'b1, byte_op: byte_op};
      @(negedge clk);
      req.wr = 1'b0;
   endtask

   // decode depends on the address alone
   task automatic probe_decode(input logic [12:0] addr);
      @(negedge clk);
      req.addr = addr;
      @(posedge clk);
      check_bit({test_name, " decode"}, expected_decode(addr), decode);
   endtask

   task automatic wait_csr_flag(input logic [12:0] addr);
      word_t d;
      d = '0;
      while (!d[CSR_DONE_BIT])
         bus_read(addr, 1'b0, 1'b0, d);
   endtask

   task automatic send_frame(input byte_t b);
      @(negedge clk);
      rs232_rx = 1'b0;
      repeat (BIT_CLKS) @(negedge clk);
      for (int i = 0; i < 8; i++)
      begin
         rs232_rx = b[i];
         repeat (BIT_CLKS) @(negedge clk);
      end
      rs232_rx = 1'b1;
      repeat (BIT_CLKS) @(negedge clk);
   endtask

   task automatic pulse_ack();
      @(negedge clk);
      interrupt_ack = 1'b1;
      @(negedge clk);
      interrupt_ack = 1'b0;
   endtask

   // every checked register read is compared with the model
   always @(posedge clk)
   begin
      if (req.rd && check_en)
      begin
         check_word(test_name, expected_rdata(req.addr, req.byte_op), rdata);
         check_bit({test_name, " decode"}, expected_decode(req.addr), decode);
      end
   end

   // line monitor samples rs232_tx in the middle of each bit
   initial
   begin
      byte_t b;
      b = '0;
      wait (reset === 1'b0);
      forever
      begin
         @(negedge rs232_tx);
         repeat (BIT_CLKS / 2) @(negedge clk);
         if (rs232_tx !== 1'b0)
         begin
            errors++;
            $display("start bit on rs232_tx did not last half a bit");
         end
         else
         begin
            for (int i = 0; i < 8; i++)
            begin
               repeat (BIT_CLKS) @(negedge clk);
               b[i] = rs232_tx;
            end
            repeat (BIT_CLKS) @(negedge clk);
            if (rs232_tx !== 1'b1)
            begin
               errors++;
               $display("frame on rs232_tx has no stop bit");
            end
            else
               tx_seen.push_back(b);
         end
      end
   end

   always @(posedge clk)
      cycle_count++;

   initial
   begin
      wait (cycle_count >= TIMEOUT_CYCLES);
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      word_t w;
      byte_t b;
      req           = '0;
      interrupt_ack = 1'b0;
      rs232_rx      = 1'b1;
      reset         = 1'b1;
      check_en      = 1'b0;
      lcg_state     = 32'd17;
      errors        = 0;
      checks        = 0;
      cycle_count   = 0;
      m_xbuf        = '0;
      m_rbuf        = '0;
      m_rx_ie       = 1'b0;
      m_tx_ie       = 1'b0;
      m_rx_done     = 1'b0;
      m_tx_ready    = 1'b1;
      test_name     = "reset";
      repeat (3) @(negedge clk);
      reset = 1'b0;
      // tx_empty takes a few cycles to reach XCSR
      repeat (4) @(negedge clk);

      check_bit("reset interrupt", 1'b0, interrupt);
      bus_read(BASE_ADDR + REG_RCSR, 1'b0, 1'b1, w);
      bus_read(BASE_ADDR + REG_XCSR, 1'b0, 1'b1, w);
      bus_read(BASE_ADDR + REG_XBUF, 1'b0, 1'b1, w);
      test_name = "decode";
      for (int i = 0; i < 4; i++)
         probe_decode(BASE_ADDR + 13'(2 * i));
      probe_decode(BASE_ADDR - 13'd2);
      probe_decode(BASE_ADDR + 13'd8);
      bus_read(BASE_ADDR - 13'd2, 1'b0, 1'b1, w);
      bus_read(BASE_ADDR + 13'd8, 1'b0, 1'b1, w);

      test_name = "transmit";
      for (int n = 0; n < 8; n++)
      begin
         w = next_random();
         bus_write(BASE_ADDR + REG_XBUF, w, 1'b0);
         m_xbuf = w;
         wait_csr_flag(BASE_ADDR + REG_XCSR);
         bus_read(BASE_ADDR + REG_XBUF, 1'b0, 1'b1, w);
         if (tx_seen.size() == 0)
         begin
            errors++;
            $display("no frame seen on rs232_tx after XBUF write %0d", n);
         end
         else
            check_byte("transmit byte", m_xbuf[7:0], tx_seen.pop_front());
      end

      test_name = "receive";
      for (int n = 0; n < 8; n++)
      begin
         w = next_random();
         b = w[7:0];
         send_frame(b);
         wait_csr_flag(BASE_ADDR + REG_RCSR);
         m_rbuf    = b;
         m_rx_done = 1'b1;
         bus_read(BASE_ADDR + REG_RCSR, 1'b0, 1'b1, w);
         bus_read(BASE_ADDR + REG_RBUF, 1'b0, 1'b1, w);
         m_rx_done = 1'b0;
         bus_read(BASE_ADDR + REG_RCSR, 1'b0, 1'b1, w);
      end

      test_name = "byte lanes";
      bus_read(BASE_ADDR + REG_XBUF + 13'd1, 1'b1, 1'b1, w);
      bus_read(BASE_ADDR + REG_XBUF, 1'b1, 1'b1, w);
      bus_write(BASE_ADDR + REG_XCSR + 13'd1, 16'h4000, 1'b1);
      m_tx_ie = 1'b1;
      bus_read(BASE_ADDR + REG_XCSR, 1'b0, 1'b1, w);
      bus_read(BASE_ADDR + REG_XCSR + 13'd1, 1'b1, 1'b1, w);

      // idle transmitter interrupts as soon as its enable is set
      test_name = "interrupts";
      repeat (2) @(negedge clk);
      check_bit("tx idle interrupt", 1'b1, interrupt);
      check_byte("tx idle vector", VEC_TX, vector);
      bus_write(BASE_ADDR + REG_RCSR, 16'h0040, 1'b0);
      m_rx_ie = 1'b1;
      w = next_random();
      b = w[7:0];
      send_frame(b);
      wait_csr_flag(BASE_ADDR + REG_RCSR);
      m_rbuf    = b;
      m_rx_done = 1'b1;
      repeat (2) @(negedge clk);
      check_bit("rx interrupt", 1'b1, interrupt);
      check_byte("rx vector", VEC_RX, vector);
      pulse_ack();
      repeat (2) @(negedge clk);
      check_bit("interrupt after first ack", 1'b1, interrupt);
      check_byte("vector after first ack", VEC_TX, vector);
      pulse_ack();
      repeat (2) @(negedge clk);
      check_bit("interrupt after second ack", 1'b0, interrupt);
      bus_read(BASE_ADDR + REG_RBUF, 1'b0, 1'b1, w);
      m_rx_done = 1'b0;

      bus_write(BASE_ADDR + REG_RCSR, 16'h0000, 1'b0);
      bus_write(BASE_ADDR + REG_XCSR, 16'h0000, 1'b0);
      m_rx_ie = 1'b0;
      m_tx_ie = 1'b0;
      w = next_random();
      b = w[7:0];
      send_frame(b);
      wait_csr_flag(BASE_ADDR + REG_RCSR);
      m_rbuf    = b;
      m_rx_done = 1'b1;
      repeat (3) @(negedge clk);
      check_bit("interrupt with enables clear", 1'b0, interrupt);
      bus_read(BASE_ADDR + REG_RBUF, 1'b0, 1'b1, w);
      m_rx_done = 1'b0;
      bus_read(BASE_ADDR + REG_RCSR, 1'b0, 1'b1, w);

      repeat (4) @(negedge clk);
      // only the written bytes may appear on the line
      if (tx_seen.size() != 0)
      begin
         errors++;
         $display("rs232_tx sent %0d frames that were never written", tx_seen.size());
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== tb.f ====
dl11_pkg.sv
dl11_brg.sv
dl11_uart_tx.sv
dl11_uart_rx.sv
dl11_regs.sv
dl11_top.sv
tb_dl11.sv

// ==== Bender.yml ====
package:
  name: dl11

sources:
  - dl11_pkg.sv
  - dl11_brg.sv
  - dl11_uart_tx.sv
  - dl11_uart_rx.sv
  - dl11_regs.sv
  - dl11_top.sv
  - target: test
    files:
      - tb_dl11.sv
